// ==== source/cu_pkg.sv ====
`default_nettype none

package cu_pkg;

	// Opcode numbering of the full ISA with only the kept instructions listed
	typedef enum logic [6:0]
	{
		BEQ = 7'd1, BNE, BC, BNC, BN, BGE, BLT, BRA,	// Conditional branches 1 to 8
		ADD = 7'd9, ADDC, SUB, SUBC, DADD, CMP,		// Register ALU group 9 to 20
		XOR, AND, OR, BIT, BIC, BIS,
		MOV = 7'd21,
		SETCC = 7'd30, CLRCC = 7'd31, CEX = 7'd32
	} opcode_e;

	typedef enum logic [2:0]
	{
		CYC_FETCH = 3'd1,
		CYC_PC_ADV = 3'd2,		// ALU adds 2 to PC
		CYC_IR_LOAD = 3'd3,		// MDR into IR
		CYC_DECODE = 3'd4,
		CYC_EXECUTE = 3'd5
	} cycle_e;

	typedef enum logic [3:0]
	{
		EQ, NE, CS, CC, MI, PL, VS, VC,
		HI, LS, GE, LT, GT, LE, AL			// 15 is unused and never true
	} cond_e;

	typedef enum logic [1:0]
	{
		SRC_MDR = 2'd0,		// MDR or MAR depending on bus
		SRC_REGFILE = 2'd1,
		SRC_IR = 2'd2,
		SRC_ALU = 2'd3
	} bus_src_e;

	typedef struct packed
	{
		opcode_e op;
		cond_e cond_c;		// CEX condition
		logic [2:0] cex_t;		// CEX true count
		logic [2:0] cex_f;		// CEX false count
		logic [4:0] pswb;		// SETCC/CLRCC flag mask
		logic [2:0] dst;
		logic [2:0] srccon;
		logic wb;			// 1 = byte
		logic rc;			// 1 = constant table
	} ir_fields_t;

	typedef struct packed
	{
		logic wb;
		logic src_ext;		// Upper source code bit, set only in the no transfer value
		bus_src_e src;
		logic dst_ext;
		bus_src_e dst;
	} bus_ctrl_t;

	typedef struct packed
	{
		logic alu_en;
		logic id_en;
		logic sxt_en;
		bus_ctrl_t data_bus;
		bus_ctrl_t addr_bus;
		logic [1:0] psw_bus;		// 0 = from ALU, 3 = none
		logic psw_update;
		logic [5:0] alu_op;
		logic [4:0] dbus_rnum_dst;
		logic [4:0] dbus_rnum_src;
		logic [4:0] alu_rnum_dst;
		logic [4:0] alu_rnum_src;
		logic [4:0] addr_rnum_src;
		logic s_bus_sel;		// 1 = sign extender onto S bus
		logic sxt_bus_sel;		// 1 = offset from decoder
		logic sxt_shift;
		logic [4:0] sxt_bit_num;
	} ctrl_word_t;

	localparam bus_ctrl_t BUS_NONE = 7'h7f;
	localparam logic [1:0] PSW_BUS_ALU = 2'd0;
	localparam logic [1:0] PSW_BUS_NONE = 2'd3;

	localparam logic [4:0] RNUM_PC = 5'd7;
	localparam logic [4:0] RNUM_CONST2 = 5'd10;

	localparam int PSW_SLP_BIT = 3;
	localparam int PSW_FLAG_W = 5;			// V, SLP, N, Z, C
	localparam logic [15:0] PSW_RESET = 16'h60e0;

	localparam ctrl_word_t CTRL_IDLE = '{
		alu_en: 1'b0, id_en: 1'b0, sxt_en: 1'b0,
		data_bus: BUS_NONE, addr_bus: BUS_NONE,
		psw_bus: PSW_BUS_NONE, psw_update: 1'b0, alu_op: 6'd0,
		dbus_rnum_dst: 5'd0, dbus_rnum_src: 5'd0,
		alu_rnum_dst: 5'd0, alu_rnum_src: 5'd0, addr_rnum_src: 5'd0,
		s_bus_sel: 1'b0, sxt_bus_sel: 1'b0, sxt_shift: 1'b0, sxt_bit_num: 5'd0
	};

	// One transfer from src to dst
	function automatic bus_ctrl_t bus_move(bus_src_e src, bus_src_e dst, logic wb);
		return '{wb: wb, src_ext: 1'b0, src: src, dst_ext: 1'b0, dst: dst};
	endfunction

endpackage

`default_nettype wire

// ==== source/cycle_sequencer.sv ====
`default_nettype none

module cycle_sequencer
#(
	parameter int ADDR_W = 16
)
(
	input wire clock,
	input wire cpucycle_rst,
	input wire [ADDR_W-1:0] pc,
	input wire [ADDR_W-1:0] brkpnt,
	input wire decode_skip,		// CEX says drop this instruction
	output cu_pkg::cycle_e cycle,
	output logic halted
);

	logic restart;

	assign halted = (cycle == cu_pkg::CYC_FETCH) && (pc == brkpnt);	// Breakpoint only checked at fetch
	assign restart = (cycle == cu_pkg::CYC_EXECUTE) ||
		((cycle == cu_pkg::CYC_DECODE) && decode_skip);

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
			cycle <= cu_pkg::CYC_FETCH;
		else if (halted)
			cycle <= cu_pkg::CYC_FETCH;		// Sit in fetch until PC moves off
		else if (restart)
			cycle <= cu_pkg::CYC_FETCH;		// Every kept instruction ends here
		else
			cycle <= cu_pkg::cycle_e'(cycle + 3'd1);
	end

	// The counter stays inside the five cycle steps, also across restarts and halts
	a_cycle_range: assert property (@(posedge clock) disable iff (cpucycle_rst)
		cycle inside {[cu_pkg::CYC_FETCH:cu_pkg::CYC_EXECUTE]});

endmodule

`default_nettype wire

// ==== source/cond_eval.sv ====
`default_nettype none

module cond_eval
(
	input wire cu_pkg::ir_fields_t ir,
	input wire [15:0] psw_in,
	output logic cond_true
);

	cu_pkg::cond_e code;
	logic has_cond;		// Opcode carries a condition
	logic code_hit;
	logic flag_c, flag_z, flag_n, flag_v;

	assign flag_c = psw_in[0];
	assign flag_z = psw_in[1];
	assign flag_n = psw_in[2];
	assign flag_v = psw_in[4];

	always_comb
	begin
		has_cond = 1'b1;
		code = cu_pkg::AL;
		case (ir.op)
			cu_pkg::BEQ: code = cu_pkg::EQ;
			cu_pkg::BNE: code = cu_pkg::NE;
			cu_pkg::BC: code = cu_pkg::CS;
			cu_pkg::BNC: code = cu_pkg::CC;
			cu_pkg::BN: code = cu_pkg::MI;
			cu_pkg::BGE: code = cu_pkg::GE;
			cu_pkg::BLT: code = cu_pkg::LT;
			cu_pkg::BRA: code = cu_pkg::AL;
			cu_pkg::CEX: code = ir.cond_c;		// Condition comes from the instruction
			default: has_cond = 1'b0;
		endcase
	end

	always_comb
	begin
		case (code)
			cu_pkg::EQ: code_hit = flag_z;
			cu_pkg::NE: code_hit = !flag_z;
			cu_pkg::CS: code_hit = flag_c;
			cu_pkg::CC: code_hit = !flag_c;
			cu_pkg::MI: code_hit = flag_n;
			cu_pkg::PL: code_hit = !flag_n;
			cu_pkg::VS: code_hit = flag_v;
			cu_pkg::VC: code_hit = !flag_v;
			cu_pkg::HI: code_hit = flag_c && !flag_z;
			cu_pkg::LS: code_hit = !flag_c || flag_z;
			cu_pkg::GE: code_hit = (flag_n == flag_v);
			cu_pkg::LT: code_hit = (flag_n != flag_v);
			cu_pkg::GT: code_hit = !flag_z && (flag_n == flag_v);
			cu_pkg::LE: code_hit = flag_z || (flag_n != flag_v);
			cu_pkg::AL: code_hit = 1'b1;
			default: code_hit = 1'b0;		// Code 15
		endcase
	end

	assign cond_true = has_cond && code_hit;

endmodule

`default_nettype wire

// ==== source/cex_tracker.sv ====
`default_nettype none

module cex_tracker
#(
	parameter int CEX_CNT_W = 3
)
(
	input wire clock,
	input wire cpucycle_rst,
	input wire cu_pkg::cycle_e cycle,
	input wire cu_pkg::ir_fields_t ir,
	input wire cond_true,
	output logic decode_skip
);

	typedef struct packed
	{
		logic active;				// Window open
		logic result;				// CEX condition outcome
		logic [CEX_CNT_W-1:0] t_cnt;		// Instructions left in true part
		logic [CEX_CNT_W-1:0] f_cnt;		// Instructions left in false part
	} cex_state_t;

	cex_state_t st;
	logic run_ok;
	logic [CEX_CNT_W-1:0] t_nxt, f_nxt;

	assign run_ok = !st.active ||
		(st.result && (st.t_cnt != '0)) ||
		(!st.result && (st.t_cnt == '0) && (st.f_cnt != '0));
	assign decode_skip = (cycle == cu_pkg::CYC_DECODE) && !run_ok;

	// True part drains first, then false part
	assign t_nxt = (st.t_cnt != '0) ? st.t_cnt - 1'b1 : st.t_cnt;
	assign f_nxt = ((st.t_cnt == '0) && (st.f_cnt != '0)) ? st.f_cnt - 1'b1 : st.f_cnt;

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
			st <= '0;
		else if ((cycle == cu_pkg::CYC_EXECUTE) && (ir.op == cu_pkg::CEX))
		begin
			st.active <= 1'b1;
			st.result <= cond_true;
			st.t_cnt <= CEX_CNT_W'(ir.cex_t);
			st.f_cnt <= CEX_CNT_W'(ir.cex_f);
		end
		else if (cycle == cu_pkg::CYC_DECODE)
		begin
			st.t_cnt <= t_nxt;
			st.f_cnt <= f_nxt;
			if ((t_nxt == '0) && (f_nxt == '0))
				st.active <= 1'b0;		// Window spent
		end
	end

	// A skip is raised at decode and the sequencer restarts on the next edge
	a_skip_restart: assert property (@(posedge clock) disable iff (cpucycle_rst)
		decode_skip |-> (cycle == cu_pkg::CYC_DECODE) ##1 (cycle == cu_pkg::CYC_FETCH));

endmodule

`default_nettype wire

// ==== source/exec_ctrl.sv ====
`default_nettype none

module exec_ctrl
(
	input wire clock,
	input wire cpucycle_rst,
	input wire cu_pkg::cycle_e cycle,
	input wire halted,
	input wire decode_skip,
	input wire cu_pkg::ir_fields_t ir,
	input wire cond_true,
	input wire [15:0] psw_in,
	output cu_pkg::ctrl_word_t ctrl,
	output logic [15:0] psw_out
);

	cu_pkg::ctrl_word_t ctrl_nxt;
	logic [15:0] psw_nxt;
	logic [4:0] op_rel;		// Position inside ADD..BIS
	logic [4:0] rnum_dst;
	logic [4:0] rnum_src;

	assign op_rel = 5'(ir.op - cu_pkg::ADD);
	assign rnum_dst = {2'b00, ir.dst};
	assign rnum_src = {2'b00, ir.srccon};

	always_comb
	begin
		ctrl_nxt = cu_pkg::CTRL_IDLE;
		if (!halted)
		begin
			case (cycle)
				cu_pkg::CYC_FETCH:
				begin
					ctrl_nxt.addr_bus = cu_pkg::bus_move(cu_pkg::SRC_REGFILE, cu_pkg::SRC_MDR, 1'b0);	// PC to MAR
					ctrl_nxt.addr_rnum_src = cu_pkg::RNUM_PC;
					ctrl_nxt.alu_rnum_dst = cu_pkg::RNUM_PC;		// Set up PC + 2
					ctrl_nxt.alu_rnum_src = cu_pkg::RNUM_CONST2;
					ctrl_nxt.alu_op = 6'd0;				// ADD
				end
				cu_pkg::CYC_PC_ADV:
				begin
					ctrl_nxt.alu_en = 1'b1;
					ctrl_nxt.data_bus = cu_pkg::bus_move(cu_pkg::SRC_ALU, cu_pkg::SRC_REGFILE, 1'b0);
					ctrl_nxt.alu_rnum_dst = cu_pkg::RNUM_PC;
					ctrl_nxt.alu_rnum_src = cu_pkg::RNUM_CONST2;
					ctrl_nxt.dbus_rnum_dst = cu_pkg::RNUM_PC;		// Sum written back to PC
				end
				cu_pkg::CYC_IR_LOAD:
					ctrl_nxt.data_bus = cu_pkg::bus_move(cu_pkg::SRC_MDR, cu_pkg::SRC_IR, 1'b0);
				cu_pkg::CYC_DECODE:
					ctrl_nxt.id_en = !decode_skip;		// Skipped instructions are never decoded
				cu_pkg::CYC_EXECUTE:
				begin
					case (ir.op) inside
						[cu_pkg::BEQ:cu_pkg::BRA]:
						begin
							if (cond_true)				// Not taken leaves the idle word
							begin
								ctrl_nxt.sxt_en = 1'b1;
								ctrl_nxt.alu_en = 1'b1;
								ctrl_nxt.sxt_bit_num = 5'd10;		// Offset sign bit
								ctrl_nxt.sxt_shift = 1'b1;		// Word offset
								ctrl_nxt.sxt_bus_sel = 1'b1;
								ctrl_nxt.s_bus_sel = 1'b1;
								ctrl_nxt.alu_rnum_dst = cu_pkg::RNUM_PC;
								ctrl_nxt.dbus_rnum_dst = cu_pkg::RNUM_PC;
								ctrl_nxt.data_bus = cu_pkg::bus_move(cu_pkg::SRC_ALU,
									cu_pkg::SRC_REGFILE, 1'b0);
							end
						end
						[cu_pkg::ADD:cu_pkg::BIS]:
						begin
							ctrl_nxt.alu_en = 1'b1;
							ctrl_nxt.alu_op = {op_rel, ir.wb};		// 2 * (op - 9) + wb
							ctrl_nxt.alu_rnum_src = {1'b0, ir.rc, ir.srccon};	// Constants from 8 up
							ctrl_nxt.alu_rnum_dst = rnum_dst;
							ctrl_nxt.dbus_rnum_dst = rnum_dst;
							ctrl_nxt.psw_update = 1'b1;
							ctrl_nxt.psw_bus = cu_pkg::PSW_BUS_ALU;
							ctrl_nxt.data_bus = cu_pkg::bus_move(cu_pkg::SRC_ALU,
								cu_pkg::SRC_REGFILE, ir.wb);
						end
						cu_pkg::MOV:
						begin
							ctrl_nxt.dbus_rnum_src = rnum_src;
							ctrl_nxt.dbus_rnum_dst = rnum_dst;
							ctrl_nxt.data_bus = cu_pkg::bus_move(cu_pkg::SRC_REGFILE,
								cu_pkg::SRC_REGFILE, ir.wb);
						end
						default: ;		// SETCC, CLRCC, CEX and unknown opcodes drive nothing
					endcase
				end
				default: ;
			endcase
		end
	end

	always_comb
	begin
		psw_nxt = psw_in;
		psw_nxt[cu_pkg::PSW_SLP_BIT] = halted;		// Sleep while parked on breakpoint
		if (cycle == cu_pkg::CYC_EXECUTE)
		begin
			if (ir.op == cu_pkg::SETCC)
				psw_nxt[cu_pkg::PSW_FLAG_W-1:0] = psw_in[cu_pkg::PSW_FLAG_W-1:0] | ir.pswb;
			else if (ir.op == cu_pkg::CLRCC)
				psw_nxt[cu_pkg::PSW_FLAG_W-1:0] = psw_in[cu_pkg::PSW_FLAG_W-1:0] & ~ir.pswb;
		end
	end

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
		begin
			ctrl <= cu_pkg::CTRL_IDLE;
			psw_out <= cu_pkg::PSW_RESET;
		end
		else
		begin
			ctrl <= ctrl_nxt;
			psw_out <= psw_nxt;
		end
	end

	// Halt from the sequencer must show as an idle word and a sleeping PSW
	a_halt_idle: assert property (@(posedge clock) disable iff (cpucycle_rst)
		halted |=> (ctrl == cu_pkg::CTRL_IDLE) && psw_out[cu_pkg::PSW_SLP_BIT]);

endmodule

`default_nettype wire

// ==== source/control_unit.sv ====
`default_nettype none

module control_unit
#(
	parameter int ADDR_W = 16,
	parameter int CEX_CNT_W = 3
)
(
	input wire clock,
	input wire cpucycle_rst,
	input wire [ADDR_W-1:0] pc,
	input wire [ADDR_W-1:0] brkpnt,
	input wire cu_pkg::ir_fields_t ir,
	input wire [15:0] psw_in,
	output cu_pkg::cycle_e cycle,
	output cu_pkg::ctrl_word_t ctrl,
	output logic [15:0] psw_out
);

	logic halted;			// Parked on breakpoint
	logic decode_skip;		// CEX drops current instruction
	logic cond_true;		// Branch or CEX condition holds

	cycle_sequencer #(.ADDR_W(ADDR_W)) i_cycle_sequencer
	(
		.clock(clock),
		.cpucycle_rst(cpucycle_rst),
		.pc(pc),
		.brkpnt(brkpnt),
		.decode_skip(decode_skip),
		.cycle(cycle),
		.halted(halted)
	);

	cond_eval i_cond_eval
	(
		.ir(ir),
		.psw_in(psw_in),
		.cond_true(cond_true)
	);

	cex_tracker #(.CEX_CNT_W(CEX_CNT_W)) i_cex_tracker
	(
		.clock(clock),
		.cpucycle_rst(cpucycle_rst),
		.cycle(cycle),
		.ir(ir),
		.cond_true(cond_true),
		.decode_skip(decode_skip)
	);

	exec_ctrl i_exec_ctrl
	(
		.clock(clock),
		.cpucycle_rst(cpucycle_rst),
		.cycle(cycle),
		.halted(halted),
		.decode_skip(decode_skip),
		.ir(ir),
		.cond_true(cond_true),
		.psw_in(psw_in),
		.ctrl(ctrl),
		.psw_out(psw_out)
	);

endmodule

`default_nettype wire

// ==== tb/control_unit_tb.sv ====
`default_nettype none

module control_unit_tb;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 8;
	localparam int REC_W = 20;			// Words per stimulus record
	localparam int REC_MAX = 32;
	localparam int HALT_CYCLES = 4;		// Cycles watched while parked on breakpoint
	localparam int STEP_LIMIT = 8;		// Longest wait for an instruction to finish
	localparam int X_SKIP = 12;			// Offsets of the expected columns
	localparam int X_DBUS = 13;
	localparam int X_ALUOP = 14;
	localparam int X_ASRC = 15;
	localparam int X_PUPD = 16;
	localparam int X_SXT = 17;
	localparam int X_FLAGS = 18;
	localparam int X_HALT = 19;

	logic clock;
	logic cpucycle_rst;
	logic [15:0] pc;
	logic [15:0] brkpnt;
	cu_pkg::ir_fields_t ir;
	logic [15:0] psw_in;
	cu_pkg::cycle_e cycle;
	cu_pkg::ctrl_word_t ctrl;
	logic [15:0] psw_out;

	logic [15:0] stim_mem [0:REC_W*REC_MAX-1];
	int rec_count;
	int cur_rec;
	int mismatches;
	int failures;
	logic load_done;

	control_unit #(.ADDR_W(16), .CEX_CNT_W(3)) i_dut
	(
		.clock(clock),
		.cpucycle_rst(cpucycle_rst),
		.pc(pc),
		.brkpnt(brkpnt),
		.ir(ir),
		.psw_in(psw_in),
		.cycle(cycle),
		.ctrl(ctrl),
		.psw_out(psw_out)
	);

	initial
	begin
		clock = 1'b0;
		forever #(CLK_PERIOD/2) clock = ~clock;
	end

	task automatic show_mismatch(input string name, input logic [79:0] got,
		input logic [79:0] exp);
		$display("Mismatch %s: got %0h expected %0h in record %0d", name, got, exp, cur_rec);
		mismatches++;
	endtask

	task automatic record_failure(input string msg);
		$display("%s", msg);
		failures++;
	endtask

	// Inputs are applied at the falling edge while the DUT sits in fetch
	task automatic drive_inputs(input int b);
		ir.op = cu_pkg::opcode_e'(stim_mem[b][6:0]);
		ir.cond_c = cu_pkg::cond_e'(stim_mem[b+1][3:0]);
		ir.cex_t = stim_mem[b+2][2:0];
		ir.cex_f = stim_mem[b+3][2:0];
		ir.pswb = stim_mem[b+4][4:0];
		ir.dst = stim_mem[b+5][2:0];
		ir.srccon = stim_mem[b+6][2:0];
		ir.wb = stim_mem[b+7][0];
		ir.rc = stim_mem[b+8][0];
		psw_in = stim_mem[b+9];
		pc = stim_mem[b+10];
		brkpnt = stim_mem[b+11];
	endtask

	// Register numbers and idle words that the record columns leave open
	task automatic check_word_detail(input int b);
		logic [6:0] op;
		logic [4:0] dst;
		logic [4:0] src;
		op = stim_mem[b][6:0];
		dst = 5'(stim_mem[b+5][2:0]);
		src = 5'(stim_mem[b+6][2:0]);
		if (stim_mem[b+X_SKIP][0])
		begin
			if (ctrl !== cu_pkg::CTRL_IDLE)		// Skipped decode keeps id_en low
				show_mismatch("ctrl", ctrl, cu_pkg::CTRL_IDLE);
		end
		else if ((op >= cu_pkg::ADD) && (op <= cu_pkg::BIS))
		begin
			if (ctrl.alu_rnum_dst !== dst)
				show_mismatch("alu_rnum_dst", ctrl.alu_rnum_dst, dst);
			if (ctrl.dbus_rnum_dst !== dst)
				show_mismatch("dbus_rnum_dst", ctrl.dbus_rnum_dst, dst);
		end
		else if (op == cu_pkg::MOV)
		begin
			if (ctrl.dbus_rnum_src !== src)
				show_mismatch("dbus_rnum_src", ctrl.dbus_rnum_src, src);
			if (ctrl.dbus_rnum_dst !== dst)
				show_mismatch("dbus_rnum_dst", ctrl.dbus_rnum_dst, dst);
		end
		else if ((op >= cu_pkg::BEQ) && (op <= cu_pkg::BRA) && !stim_mem[b+X_SXT][0])
		begin
			if (ctrl !== cu_pkg::CTRL_IDLE)		// Branch not taken
				show_mismatch("ctrl", ctrl, cu_pkg::CTRL_IDLE);
		end
	endtask

	task automatic run_record(input int r);
		int b;
		int steps;
		logic saw_exec;
		logic back_to_fetch;
		b = r * REC_W;
		cur_rec = r;
		drive_inputs(b);
		saw_exec = 1'b0;
		if (stim_mem[b+X_HALT][0])
		begin
			repeat (HALT_CYCLES)		// Counter must sit in fetch
			begin
				@(negedge clock);
				if (cycle !== cu_pkg::CYC_FETCH)
					show_mismatch("cycle", cycle, cu_pkg::CYC_FETCH);
			end
			if (ctrl !== cu_pkg::CTRL_IDLE)
				show_mismatch("ctrl", ctrl, cu_pkg::CTRL_IDLE);
		end
		else
		begin
			steps = 0;
			back_to_fetch = 1'b0;
			while (!back_to_fetch && (steps < STEP_LIMIT))
			begin
				@(negedge clock);
				steps++;
				if (cycle == cu_pkg::CYC_EXECUTE)
					saw_exec = 1'b1;
				back_to_fetch = (cycle == cu_pkg::CYC_FETCH);		// Word of last step is now on ctrl
			end
			if (!back_to_fetch)
			begin
				record_failure($sformatf("Record %0d never reached execute or a skip", r));
				return;
			end
			if (!saw_exec !== stim_mem[b+X_SKIP][0])
				show_mismatch("skipped", !saw_exec, stim_mem[b+X_SKIP][0]);
			check_word_detail(b);
		end
		if (ctrl.data_bus !== stim_mem[b+X_DBUS][6:0])
			show_mismatch("data_bus", ctrl.data_bus, stim_mem[b+X_DBUS][6:0]);
		if (ctrl.alu_op !== stim_mem[b+X_ALUOP][5:0])
			show_mismatch("alu_op", ctrl.alu_op, stim_mem[b+X_ALUOP][5:0]);
		if (ctrl.alu_rnum_src !== stim_mem[b+X_ASRC][4:0])
			show_mismatch("alu_rnum_src", ctrl.alu_rnum_src, stim_mem[b+X_ASRC][4:0]);
		if (ctrl.psw_update !== stim_mem[b+X_PUPD][0])
			show_mismatch("psw_update", ctrl.psw_update, stim_mem[b+X_PUPD][0]);
		if (ctrl.sxt_en !== stim_mem[b+X_SXT][0])
			show_mismatch("sxt_en", ctrl.sxt_en, stim_mem[b+X_SXT][0]);
		if (psw_out[4:0] !== stim_mem[b+X_FLAGS][4:0])		// Includes the sleep bit
			show_mismatch("psw_out", psw_out[4:0], stim_mem[b+X_FLAGS][4:0]);
	endtask

	initial
	begin
		cpucycle_rst = 1'b1;
		pc = 16'h0000;
		brkpnt = 16'hffff;		// Far from pc so reset ends without a halt
		ir = '0;
		psw_in = 16'h0000;
		mismatches = 0;
		failures = 0;
		cur_rec = -1;
		load_done = 1'b0;
		for (int i = 0; i < REC_W*REC_MAX; i++)
			stim_mem[i] = 16'h8000 | 16'(i);		// Bit 15 marks words the file left empty
		$readmemh("tb/control_unit_stimulus.txt", stim_mem);
		rec_count = 0;
		while ((rec_count < REC_MAX) && !stim_mem[rec_count*REC_W][15])
			rec_count++;
		load_done = 1'b1;
		repeat (RESET_CYCLES) @(negedge clock);
		cpucycle_rst = 1'b0;
		if (ctrl !== cu_pkg::CTRL_IDLE)		// State right after reset
			show_mismatch("ctrl", ctrl, cu_pkg::CTRL_IDLE);
		if (psw_out !== cu_pkg::PSW_RESET)
			show_mismatch("psw_out", psw_out, cu_pkg::PSW_RESET);
		if (rec_count == 0)
			record_failure("The stimulus file held no records");
		for (int r = 0; r < rec_count; r++)
			run_record(r);
		$display("Summary: %0d records, %0d mismatches, %0d other failures",
			rec_count, mismatches, failures);
		if ((mismatches + failures) == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// Six cycles per record is more than the longest instruction
	initial
	begin
		wait (load_done);
		#((rec_count * 6 + RESET_CYCLES) * CLK_PERIOD);
		$display("Watchdog expired before all %0d records had run", rec_count);
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/control_unit_stimulus.txt ====
// op cc ct cf pswb dst src wb rc psw_in pc brkpnt   (inputs)
// skip data_bus alu_op alu_rnum_src psw_update sxt_en psw_flags halt   (expected)
09 0 0 0 00 3 5 0 0 60e0 0100 ffff  0 19 00 05 1 0 00 0  // ADD
0c 0 0 0 00 6 2 1 1 0015 0100 ffff  0 59 07 0a 1 0 15 0  // SUBC byte, constant source
14 0 0 0 00 0 7 0 1 60ea 0100 ffff  0 19 16 0f 1 0 02 0  // BIS, sleep bit cleared
15 0 0 0 00 2 4 1 0 0004 0100 ffff  0 49 00 00 0 0 04 0  // MOV byte
01 0 0 0 00 0 0 0 0 0002 0100 ffff  0 19 00 00 0 1 02 0  // BEQ taken
01 0 0 0 00 0 0 0 0 0000 0100 ffff  0 7f 00 00 0 0 00 0  // BEQ not taken
02 0 0 0 00 0 0 0 0 0000 0100 ffff  0 19 00 00 0 1 00 0  // BNE taken
03 0 0 0 00 0 0 0 0 0001 0100 ffff  0 19 00 00 0 1 01 0  // BC taken
04 0 0 0 00 0 0 0 0 0001 0100 ffff  0 7f 00 00 0 0 01 0  // BNC not taken
05 0 0 0 00 0 0 0 0 0004 0100 ffff  0 19 00 00 0 1 04 0  // BN taken
06 0 0 0 00 0 0 0 0 0014 0100 ffff  0 19 00 00 0 1 14 0  // BGE taken, N and V set
07 0 0 0 00 0 0 0 0 0014 0100 ffff  0 7f 00 00 0 0 14 0  // BLT not taken
07 0 0 0 00 0 0 0 0 0010 0100 ffff  0 19 00 00 0 1 10 0  // BLT taken, V only
08 0 0 0 00 0 0 0 0 0000 0100 ffff  0 19 00 00 0 1 00 0  // BRA
1e 0 0 0 05 0 0 0 0 0002 0100 ffff  0 7f 00 00 0 0 07 0  // SETCC
1f 0 0 0 03 0 0 0 0 0017 0100 ffff  0 7f 00 00 0 0 14 0  // CLRCC
20 0 1 2 00 0 0 0 0 0002 0100 ffff  0 7f 00 00 0 0 02 0  // CEX EQ true, 1 true 2 false
09 0 0 0 00 1 1 0 0 0000 0100 ffff  0 19 00 01 1 0 00 0  // ADD in true part
09 0 0 0 00 1 1 0 0 0000 0100 ffff  1 7f 00 00 0 0 00 0  // ADD in false part, skipped
15 0 0 0 00 2 4 0 0 0000 0100 ffff  1 7f 00 00 0 0 00 0  // MOV in false part, skipped
15 0 0 0 00 2 4 0 0 0000 0100 ffff  0 09 00 00 0 0 00 0  // MOV after window
20 1 1 1 00 0 0 0 0 0002 0100 ffff  0 7f 00 00 0 0 02 0  // CEX NE false, 1 true 1 false
0b 0 0 0 00 2 3 0 0 0000 0100 ffff  1 7f 00 00 0 0 00 0  // SUB in true part, skipped
0b 0 0 0 00 2 3 0 0 0000 0100 ffff  0 19 04 03 1 0 00 0  // SUB in false part
09 0 0 0 00 1 1 0 0 0001 0200 0200  0 7f 00 00 0 0 09 1  // Breakpoint hit
0a 0 0 0 00 0 6 0 0 0001 0202 0200  0 19 02 06 1 0 01 0  // ADDC after pc moved

// ==== filelist.f ====
source/cu_pkg.sv
source/cycle_sequencer.sv
source/cond_eval.sv
source/cex_tracker.sv
source/exec_ctrl.sv
source/control_unit.sv
tb/control_unit_tb.sv

// ==== Bender.yml ====
package:
  name: control_unit

sources:
  - source/cu_pkg.sv
  - source/cycle_sequencer.sv
  - source/cond_eval.sv
  - source/cex_tracker.sv
  - source/exec_ctrl.sv
  - source/control_unit.sv
  - target: simulation
    files:
      - tb/control_unit_tb.sv
